/* fir_cfg_pkg.sv */
package fir_cfg_pkg;

	// Datapath sizes of the ten-tap FIR

	// Number of taps in both the coefficient bank and the delay line
	localparam int tap_count = 10;

	// Unsigned sample width
	localparam int sample_width = 8;

	// Unsigned coefficient width
	localparam int coeff_width = 8;

	// One product grows by sample plus coefficient bits, and the sum over all
	// taps grows by the ceiling of log2 of the tap count
	// Ten full-scale products sum to 650250, so this is the width that holds them
	localparam int result_width = sample_width + coeff_width + $clog2(tap_count);

	// Index of one tap, from 0 to tap_count - 1
	localparam int tap_index_width = $clog2(tap_count);

	// The command data bus carries either a sample or a coefficient
	localparam int data_width = (sample_width > coeff_width) ? sample_width : coeff_width;

endpackage

/* fir_coeff_bank.sv */
`timescale 1ns/1ps

module fir_coeff_bank (
	input  logic                                     clock,
	input  logic                                     arst_n,
	input  logic                                     coeff_shift,
	input  logic [fir_cfg_pkg::coeff_width-1:0]      coeff_in,
	input  logic [fir_cfg_pkg::tap_index_width-1:0]  tap_index,
	output logic [fir_cfg_pkg::coeff_width-1:0]      coeff_out
);

	import fir_cfg_pkg::*;

	// Register 0 takes the newest load, and the oldest load sits at the top
	logic [coeff_width-1:0] coeff_q [0:tap_count-1];

	// The bank starts out as all zeros, which gives a zero response
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < tap_count; i++) begin
				coeff_q[i] <= '0;
			end
		end else if (coeff_shift) begin
			// Everything moves one place up and the top entry drops out
			for (int i = tap_count - 1; i > 0; i--) begin
				coeff_q[i] <= coeff_q[i-1];
			end
			coeff_q[0] <= coeff_in;
		end
	end

	// Taps are read from the top down
	// Tap 0 gets the first coefficient loaded and meets the newest sample
	always_comb begin
		coeff_out = '0;
		if (tap_index < tap_index_width'(tap_count)) begin
			coeff_out = coeff_q[(tap_count - 1) - int'(tap_index)];
		end
	end

endmodule

/* fir_control.sv */
`timescale 1ns/1ps

module fir_control (
	input  logic                                  clock,
	input  logic                                  arst_n,
	input  logic                                  cmd_req,
	input  fir_ctrl_pkg::fir_cmd_e                cmd_op,
	input  logic [fir_cfg_pkg::data_width-1:0]    cmd_data,
	output logic                                  cmd_ack,
	output logic                                  res_req,
	input  logic                                  res_ack,
	output logic                                  coeff_shift,
	output logic [fir_cfg_pkg::coeff_width-1:0]   coeff_in,
	output logic                                  sample_shift,
	output logic                                  history_clear,
	output logic [fir_cfg_pkg::sample_width-1:0]  sample_in,
	output logic                                  mac_start,
	input  logic                                  mac_done
);

	import fir_cfg_pkg::*;
	import fir_ctrl_pkg::*;

	fir_state_e state;

	// Command data is captured on the accepting edge
	// The strobes raised on that same edge carry it to the datapath one cycle later
	always_ff @(posedge clock) begin
		if (state == st_idle && cmd_req) begin
			coeff_in  <= cmd_data[coeff_width-1:0];
			sample_in <= cmd_data[sample_width-1:0];
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state         <= st_idle;
			cmd_ack       <= 1'b0;
			res_req       <= 1'b0;
			coeff_shift   <= 1'b0;
			sample_shift  <= 1'b0;
			history_clear <= 1'b0;
			mac_start     <= 1'b0;
		end else begin
			// Strobes are one cycle wide unless a state raises them again
			coeff_shift   <= 1'b0;
			sample_shift  <= 1'b0;
			history_clear <= 1'b0;
			mac_start     <= 1'b0;

			case (state)
				st_idle: begin
					// Commands are only taken here, after both ports have returned to zero
					if (cmd_req) begin
						case (cmd_op)
							cmd_load_coeff: begin
								coeff_shift <= 1'b1;
								state       <= st_coeff;
							end
							cmd_clear_history: begin
								history_clear <= 1'b1;
								state         <= st_shift;
							end
							cmd_push_sample: begin
								// The delay line shifts and the MAC starts on the same edge,
								// so tap 0 already sees the new sample
								sample_shift <= 1'b1;
								mac_start    <= 1'b1;
								state        <= st_shift;
							end
							default: begin
								// An unused opcode is acknowledged with no effect on the datapath
								state <= st_coeff;
							end
						endcase
					end
				end

				st_coeff: begin
					// First cycle here is the bank shift, the second raises the ack
					if (!coeff_shift) begin
						cmd_ack <= 1'b1;
						state   <= st_release;
					end
				end

				st_shift: begin
					if (sample_shift) begin
						state <= st_compute;
					end else if (!history_clear) begin
						// The clear went through on the previous edge
						cmd_ack <= 1'b1;
						state   <= st_release;
					end
				end

				st_compute: begin
					// The result and the command ack are offered together
					if (mac_done) begin
						res_req <= 1'b1;
						cmd_ack <= 1'b1;
						state   <= st_present;
					end
				end

				st_present: begin
					// The host may finish the command handshake while the result waits
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
					end
					// The result stays up until the host takes it
					if (res_ack) begin
						res_req <= 1'b0;
						state   <= st_release;
					end
				end

				st_release: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
					end
					// Idle again once both request lines are low
					if (!cmd_req && !res_ack) begin
						state <= st_idle;
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* fir_ctrl_pkg.sv */
package fir_ctrl_pkg;

	// Opcodes on the command port
	typedef enum logic [1:0] {
		// Shift one coefficient into the bank
		cmd_load_coeff    = 2'd0,
		// Push one sample and compute one result
		cmd_push_sample   = 2'd1,
		// Zero the whole sample history
		cmd_clear_history = 2'd2
	} fir_cmd_e;

	// States of the control FSM
	typedef enum logic [2:0] {
		st_idle    = 3'd0,
		st_coeff   = 3'd1,
		st_shift   = 3'd2,
		st_compute = 3'd3,
		st_present = 3'd4,
		st_release = 3'd5
	} fir_state_e;

endpackage

/* fir_delay_line.sv */
`timescale 1ns/1ps

module fir_delay_line (
	input  logic                                     clock,
	input  logic                                     arst_n,
	input  logic                                     sample_shift,
	input  logic                                     history_clear,
	input  logic [fir_cfg_pkg::sample_width-1:0]     sample_in,
	input  logic [fir_cfg_pkg::tap_index_width-1:0]  tap_index,
	output logic [fir_cfg_pkg::sample_width-1:0]     sample_out
);

	import fir_cfg_pkg::*;

	// Index 0 is the newest sample and the top index the oldest one kept
	logic [sample_width-1:0] sample_q [0:tap_count-1];

	// Samples from before reset count as zero
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < tap_count; i++) begin
				sample_q[i] <= '0;
			end
		end else if (history_clear) begin
			// Zero the whole history, so later sums only see new samples
			for (int i = 0; i < tap_count; i++) begin
				sample_q[i] <= '0;
			end
		end else if (sample_shift) begin
			for (int i = tap_count - 1; i > 0; i--) begin
				sample_q[i] <= sample_q[i-1];
			end
			sample_q[0] <= sample_in;
		end
	end

	// The tap index is the age of the sample that is read
	always_comb begin
		sample_out = '0;
		if (tap_index < tap_index_width'(tap_count)) begin
			sample_out = sample_q[tap_index];
		end
	end

endmodule

/* fir_filter_top.sv */
`timescale 1ns/1ps

module fir_filter_top (
	input  logic                                   clock,
	input  logic                                   arst_n,
	input  logic                                   cmd_req,
	input  fir_ctrl_pkg::fir_cmd_e                 cmd_op,
	input  logic [fir_cfg_pkg::data_width-1:0]     cmd_data,
	output logic                                   cmd_ack,
	output logic                                   res_req,
	input  logic                                   res_ack,
	output logic [fir_cfg_pkg::result_width-1:0]   res_data
);

	import fir_cfg_pkg::*;

	// Strobes and data from the FSM to the two storage blocks
	logic                    coeff_shift;
	logic [coeff_width-1:0]  coeff_in;
	logic                    sample_shift;
	logic                    history_clear;
	logic [sample_width-1:0] sample_in;

	// MAC run control
	logic mac_start;
	logic mac_done;

	// The MAC addresses one tap of both stores per cycle
	logic [tap_index_width-1:0] tap_index;
	logic [coeff_width-1:0]     coeff_out;
	logic [sample_width-1:0]    sample_out;

	fir_control fir_control_inst (
		.clock         (clock),
		.arst_n        (arst_n),
		.cmd_req       (cmd_req),
		.cmd_op        (cmd_op),
		.cmd_data      (cmd_data),
		.cmd_ack       (cmd_ack),
		.res_req       (res_req),
		.res_ack       (res_ack),
		.coeff_shift   (coeff_shift),
		.coeff_in      (coeff_in),
		.sample_shift  (sample_shift),
		.history_clear (history_clear),
		.sample_in     (sample_in),
		.mac_start     (mac_start),
		.mac_done      (mac_done)
	);

	fir_coeff_bank fir_coeff_bank_inst (
		.clock       (clock),
		.arst_n      (arst_n),
		.coeff_shift (coeff_shift),
		.coeff_in    (coeff_in),
		.tap_index   (tap_index),
		.coeff_out   (coeff_out)
	);

	fir_delay_line fir_delay_line_inst (
		.clock         (clock),
		.arst_n        (arst_n),
		.sample_shift  (sample_shift),
		.history_clear (history_clear),
		.sample_in     (sample_in),
		.tap_index     (tap_index),
		.sample_out    (sample_out)
	);

	// The held MAC result is the result port data
	fir_mac fir_mac_inst (
		.clock      (clock),
		.arst_n     (arst_n),
		.mac_start  (mac_start),
		.coeff_out  (coeff_out),
		.sample_out (sample_out),
		.tap_index  (tap_index),
		.mac_done   (mac_done),
		.result     (res_data)
	);

endmodule

/* fir_mac.sv */
`timescale 1ns/1ps

module fir_mac (
	input  logic                                     clock,
	input  logic                                     arst_n,
	input  logic                                     mac_start,
	input  logic [fir_cfg_pkg::coeff_width-1:0]      coeff_out,
	input  logic [fir_cfg_pkg::sample_width-1:0]     sample_out,
	output logic [fir_cfg_pkg::tap_index_width-1:0]  tap_index,
	output logic                                     mac_done,
	output logic [fir_cfg_pkg::result_width-1:0]     result
);

	import fir_cfg_pkg::*;

	// High for exactly tap_count cycles after a start
	logic busy;

	// Sum of the taps handled so far in this run
	logic [result_width-1:0] acc;

	// Product of the tap that is addressed in this cycle
	logic [coeff_width+sample_width-1:0] product;

	// Set while the last tap is addressed
	logic last_tap;

	assign product  = coeff_out * sample_out;
	assign last_tap = (tap_index == tap_index_width'(tap_count - 1));

	// Tap walk, done pulse and the held result
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy      <= 1'b0;
			tap_index <= '0;
			mac_done  <= 1'b0;
			result    <= '0;
		end else begin
			mac_done <= 1'b0;
			if (mac_start) begin
				// Tap 0 is addressed in the first cycle of the run
				busy      <= 1'b1;
				tap_index <= '0;
			end else if (busy) begin
				if (last_tap) begin
					// Last product goes straight into the output register
					busy      <= 1'b0;
					tap_index <= '0;
					mac_done  <= 1'b1;
					result    <= acc + result_width'(product);
				end else begin
					tap_index <= tap_index + 1'b1;
				end
			end
		end
	end

	// Running sum that starts again from zero on every start
	always_ff @(posedge clock) begin
		if (mac_start) begin
			acc <= '0;
		end else if (busy) begin
			acc <= acc + result_width'(product);
		end
	end

endmodule

/* fir_tb.sv */
`timescale 1ns/1ps

module fir_tb;

	import fir_cfg_pkg::*;
	import fir_ctrl_pkg::*;

	// Room for the vector list with three words per command
	localparam int max_vectors = 64;
	// Cycles that any single wait may last
	localparam int wait_limit = 64;

	logic                    clock;
	logic                    arst_n;
	logic                    cmd_req;
	fir_cmd_e                cmd_op;
	logic [data_width-1:0]   cmd_data;
	logic                    cmd_ack;
	logic                    res_req;
	logic                    res_ack;
	logic [result_width-1:0] res_data;

	int value_errors = 0;
	int protocol_errors = 0;
	int timeout_errors = 0;

	// Opcode, data and expected result of each command, in file order
	logic [31:0] vector_mem [0:3*max_vectors-1];

	// Reference model coefficients with index 0 holding the oldest load
	int unsigned model_coeff [0:tap_count-1];
	// Sample 0 is the newest push
	int unsigned model_sample [0:tap_count-1];

	logic [31:0] rand_state;

	// Values from the previous falling edge for the protocol monitor
	logic                    ack_seen = 1'b0;
	logic                    req_seen = 1'b0;
	logic                    cmd_req_seen = 1'b0;
	logic [result_width-1:0] held_result = '0;

	fir_tb_clock fir_tb_clock_inst (
		.clock (clock)
	);

	fir_filter_top fir_filter_top_inst (
		.clock    (clock),
		.arst_n   (arst_n),
		.cmd_req  (cmd_req),
		.cmd_op   (cmd_op),
		.cmd_data (cmd_data),
		.cmd_ack  (cmd_ack),
		.res_req  (res_req),
		.res_ack  (res_ack),
		.res_data (res_data)
	);

	// Linear congruential generator for the res_ack delay
	function automatic logic [31:0] lcg_next(input logic [31:0] seed);
		return seed * 32'd1664525 + 32'd1013904223;
	endfunction

	// All driving and sampling happens 2 ns after a rising edge
	task automatic next_cycle;
		@(posedge clock);
		#2;
	endtask

	task automatic report_and_finish;
		$display("Error counts: %0d value, %0d protocol, %0d timeout",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// A timeout stops the command list, and the closing report then fails the run
	task automatic record_timeout(input string what);
		timeout_errors++;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	// Applies one command to the model and returns the sum a push produces
	task automatic apply_to_model(input fir_cmd_e op, input logic [data_width-1:0] data,
			output int unsigned sum);
		sum = 0;
		case (op)
			cmd_load_coeff: begin
				// The oldest coefficient drops out at index 0
				for (int k = 0; k < tap_count - 1; k++) begin
					model_coeff[k] = model_coeff[k+1];
				end
				model_coeff[tap_count-1] = data;
			end
			cmd_push_sample: begin
				for (int j = tap_count - 1; j > 0; j--) begin
					model_sample[j] = model_sample[j-1];
				end
				model_sample[0] = data;
				for (int k = 0; k < tap_count; k++) begin
					sum += model_coeff[k] * model_sample[k];
				end
			end
			cmd_clear_history: begin
				for (int j = 0; j < tap_count; j++) begin
					model_sample[j] = 0;
				end
			end
			default: begin
			end
		endcase
	endtask

	// One full command, with both handshakes for a push
	task automatic run_command(input logic [7:0] op_code, input logic [data_width-1:0] data,
			input logic [31:0] file_expected);
		fir_cmd_e    op;
		int unsigned model_sum;
		int          cycles;
		int          expected_cycles;
		int          ack_delay;
		op = fir_cmd_e'(op_code[1:0]);
		apply_to_model(op, data, model_sum);
		if (op == cmd_push_sample) begin
			// The file and the model must agree before the DUT is judged
			assert (file_expected == model_sum) else begin
				value_errors++;
				$display("** Error at %0t: vector expected = %h, model = %h",
					$time, file_expected, model_sum);
			end
			expected_cycles = tap_count + 2;
		end else begin
			expected_cycles = 2;
		end
		cmd_op   = op;
		cmd_data = data;
		cmd_req  = 1'b1;
		cycles   = 0;
		while (!(cmd_ack || res_req) && cycles <= wait_limit) begin
			next_cycle();
			cycles++;
		end
		if (!(cmd_ack || res_req)) begin
			record_timeout("no acknowledge came back for a command request");
		end
		// The request goes up between edges, so one more step is counted
		assert (cycles == expected_cycles + 1) else begin
			value_errors++;
			$display("** Error at %0t: cmd_ack latency = %0d cycles, expected %0d",
				$time, cycles - 1, expected_cycles);
		end
		assert (cmd_ack) else begin
			value_errors++;
			$display("** Error at %0t: cmd_ack = %b, expected 1", $time, cmd_ack);
		end
		assert (res_req == (op == cmd_push_sample)) else begin
			value_errors++;
			$display("** Error at %0t: res_req = %b, expected %b",
				$time, res_req, op == cmd_push_sample);
		end
		cmd_req = 1'b0;
		if (op == cmd_push_sample) begin
			assert (res_data == file_expected[result_width-1:0]) else begin
				value_errors++;
				$display("** Error at %0t: res_data = %h, expected %h",
					$time, res_data, file_expected[result_width-1:0]);
			end
			// The host holds off the result for a few cycles
			rand_state = lcg_next(rand_state);
			ack_delay  = (rand_state >> 16) % 6;
			repeat (ack_delay) begin
				next_cycle();
				assert (res_req) else begin
					protocol_errors++;
					$display("Protocol error at %0t: res_req fell before res_ack", $time);
				end
			end
			res_ack = 1'b1;
			cycles  = 0;
			while (res_req && cycles <= wait_limit) begin
				next_cycle();
				cycles++;
			end
			if (res_req) begin
				record_timeout("res_req stayed high after res_ack was raised");
			end
			res_ack = 1'b0;
		end
		cycles = 0;
		while (cmd_ack && cycles <= wait_limit) begin
			next_cycle();
			cycles++;
		end
		if (cmd_ack) begin
			record_timeout("cmd_ack stayed high after cmd_req was dropped");
		end
		// The FSM needs one more edge to reach idle
		next_cycle();
	endtask

	// cmd_ack may only rise under a request, and a presented result must hold still
	// The request seen at the previous falling edge is the one present at the rising edge
	always @(negedge clock) begin
		if (arst_n) begin
			if (cmd_ack && !ack_seen) begin
				assert (cmd_req_seen) else begin
					protocol_errors++;
					$display("Protocol error at %0t: cmd_ack rose while cmd_req was low", $time);
				end
			end
			if (res_req && req_seen) begin
				assert (res_data == held_result) else begin
					value_errors++;
					$display("** Error at %0t: res_data = %h while res_req high, held %h",
						$time, res_data, held_result);
				end
			end
			if (res_req && !req_seen) begin
				held_result = res_data;
			end
		end
		ack_seen     = cmd_ack;
		req_seen     = res_req;
		cmd_req_seen = cmd_req;
	end

	initial begin
		int          idx;
		logic [31:0] op_word;
		logic        list_done;
		arst_n     = 1'b0;
		cmd_req    = 1'b0;
		cmd_op     = cmd_load_coeff;
		cmd_data   = '0;
		res_ack    = 1'b0;
		rand_state = 32'hebcb_5494;
		for (int k = 0; k < tap_count; k++) begin
			model_coeff[k]  = 0;
			model_sample[k] = 0;
		end
		$readmemh("fir_vectors.txt", vector_mem);

		repeat (10) begin
			next_cycle();
		end
		arst_n = 1'b1;
		next_cycle();

		// Idle outputs and a zero result right after reset
		assert (!cmd_ack && !res_req) else begin
			protocol_errors++;
			$display("Protocol error at %0t: a handshake output is high after reset", $time);
		end
		assert (res_data == '0) else begin
			value_errors++;
			$display("** Error at %0t: res_data = %h, expected 0", $time, res_data);
		end

		// Opcode ff or an unwritten word ends the list, and so does a timeout
		idx       = 0;
		list_done = 1'b0;
		while (!list_done) begin
			if (idx >= max_vectors || timeout_errors > 0) begin
				list_done = 1'b1;
			end else begin
				op_word = vector_mem[3*idx];
				if ($isunknown(op_word) || op_word == 32'hff) begin
					list_done = 1'b1;
				end else begin
					run_command(op_word[7:0], vector_mem[3*idx+1][data_width-1:0],
						vector_mem[3*idx+2]);
					idx++;
				end
			end
		end
		assert (idx > 0) else begin
			value_errors++;
			$display("No commands could be read from fir_vectors.txt");
		end
		$display("%0d commands run", idx);
		report_and_finish();
	end

endmodule

/* fir_tb_clock.sv */
`timescale 1ns/1ps

module fir_tb_clock (
	output logic clock
);

	// Half of the 20 ns period
	localparam real half_period = 10.0;

	initial begin
		clock = 1'b0;
	end

	// The clock runs until the testbench finishes the run
	always begin
		#(half_period);
		clock = ~clock;
	end

endmodule

/* fir_vectors.txt */
// Columns: opcode (0 load coefficient, 1 push sample, 2 clear history), data, expected
// Expected is checked on pushes only, other lines carry 0; opcode ff ends the list
1 05 00000
0 03 00000
0 07 00000
0 0b 00000
0 10 00000
0 15 00000
0 1a 00000
0 20 00000
0 2a 00000
0 31 00000
0 3c 00000
2 00 00000
1 01 00003
1 00 00007
1 00 0000b
1 00 00010
1 00 00015
1 00 0001a
1 00 00020
1 00 0002a
1 00 00031
1 00 0003c
1 9c 001d4
1 4e 0052e
1 d7 00b5b
2 00 00000
1 21 00063
1 05 000f6
0 80 00000
1 11 002be
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
0 ff 00000
1 ff 134ca
1 ff 232cb
1 ff 330cc
1 ff 42ecd
1 ff 52cce
1 ff 62acf
1 ff 728d0
1 ff 805f2
1 ff 8fef8
1 ff 9ec0a
ff 00 00000

/* tb.f */
fir_cfg_pkg.sv
fir_ctrl_pkg.sv
fir_control.sv
fir_coeff_bank.sv
fir_delay_line.sv
fir_mac.sv
fir_filter_top.sv
fir_tb_clock.sv
fir_tb.sv
